//--- bench/nlc_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_checker
  import nlc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      coef_we,
  input  ch_t       coef_ch,
  input  coef_sel_e coef_sel,
  input  word_t     coef_data,
  input  logic      in_valid,
  input  logic      in_ready,
  input  ch_t       in_ch,
  input  adc_t      in_sample,
  input  logic      out_valid,
  input  logic      out_ready,
  input  ch_t       out_ch,
  input  adc_t      out_result,
  input  string     test_name,
  output int        value_errors,
  output int        chan_errors,
  output int        other_errors,
  output int        pending
);

  word_t model [`NLC_CHANNELS][8];
  adc_t  exp_res [$];
  ch_t   exp_ch [$];
  adc_t  e_res;
  ch_t   e_ch;
  logic  after_rst = 1'b0;
  logic  held = 1'b0;
  ch_t   held_ch;
  adc_t  held_res;

  // Full 64-bit product, arithmetic shift, low word kept
  function automatic word_t q_product(word_t a, word_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return word_t'(p >>> `NLC_FRAC);
  endfunction

  function automatic adc_t model_result(ch_t c, adc_t s);
    word_t  x;
    word_t  acc;
    longint whole;
    longint lim;
    lim = longint'(1) <<< (`NLC_ADC_W - 1);
    x = word_t'(s);
    x = x <<< `NLC_FRAC;
    x = q_product(x + model[c][SEL_NEG_MEAN], model[c][SEL_RECIP]);
    acc = model[c][SEL_C5];
    // Horner from c4 down to c0
    for (int k = 4; k >= 0; k--) begin
      acc = q_product(acc, x) + model[c][int'(SEL_C0) + k];
    end
    whole = longint'(acc >>> `NLC_FRAC);
    if (whole >= lim) begin
      return adc_t'(lim - 1);
    end
    if (whole < -lim) begin
      return adc_t'(-lim);
    end
    return adc_t'(whole);
  endfunction

  initial begin
    value_errors = 0;
    chan_errors = 0;
    other_errors = 0;
    pending = 0;
  end

  always @(posedge clk) begin
    if (rst) begin
      exp_res.delete();
      exp_ch.delete();
      for (int c = 0; c < `NLC_CHANNELS; c++) begin
        for (int s = 0; s < 8; s++) begin
          model[c][s] = '0;
        end
      end
      after_rst = 1'b1;
      held = 1'b0;
    end else begin
      if (after_rst && (out_valid !== 1'b0 || in_ready !== 1'b1)) begin
        $display("After reset out_valid is %b and in_ready is %b", out_valid, in_ready);
        other_errors++;
      end
      after_rst = 1'b0;
      if (held && (out_ch !== held_ch || out_result !== held_res)) begin
        $display("Output changed while stalled in test %s", test_name);
        other_errors++;
      end
      if (out_valid && out_ready) begin
        if (exp_res.size() == 0) begin
          $display("Result appeared with no sample pending in test %s", test_name);
          other_errors++;
        end else begin
          e_res = exp_res.pop_front();
          e_ch = exp_ch.pop_front();
          if (out_result !== e_res) begin
            $display("Error %s: result expected %0d, actual %0d", test_name, e_res, out_result);
            value_errors++;
          end
          if (out_ch !== e_ch) begin
            $display("Error %s: channel expected %0d, actual %0d", test_name, e_ch, out_ch);
            chan_errors++;
          end
        end
      end
      if (in_valid && in_ready) begin
        exp_res.push_back(model_result(in_ch, in_sample));
        exp_ch.push_back(in_ch);
      end
      if (coef_we) begin
        model[coef_ch][coef_sel] = coef_data;
      end
      held = out_valid && !out_ready;
      held_ch = out_ch;
      held_res = out_result;
    end
    pending = exp_res.size();
  end

endmodule

`default_nettype wire

//--- bench/nlc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_tb
  import nlc_pkg::*;
();

  localparam int NROWS = 7;
  localparam int SET_IDENT = 0;
  localparam int SET_RAND = 1;
  localparam int SET_SATP = 2;
  localparam int SET_SATN = 3;

  // Name, coefficient set, first channel, channel count, samples, stall
  string row_name  [NROWS] = '{"identity", "identity_stall", "poly_random", "chan_interleave",
                               "sat_pos", "sat_neg", "backpressure"};
  int    row_set   [NROWS] = '{SET_IDENT, SET_IDENT, SET_RAND, SET_RAND, SET_SATP, SET_SATN,
                               SET_RAND};
  int    row_ch    [NROWS] = '{0, 5, 2, 8, 12, 13, 0};
  int    row_nch   [NROWS] = '{1, 1, 3, 4, 1, 1, 4};
  int    row_nsamp [NROWS] = '{24, 24, 40, 48, 16, 16, 64};
  bit    row_stall [NROWS] = '{0, 1, 0, 0, 0, 0, 1};

  logic clk;
  logic rst;
  logic coef_we;
  ch_t coef_ch;
  coef_sel_e coef_sel;
  word_t coef_data;
  logic in_valid;
  ch_t in_ch;
  adc_t in_sample;
  logic in_ready;
  logic out_valid;
  ch_t out_ch;
  adc_t out_result;
  logic out_ready;
  string test_name;
  int value_errors;
  int chan_errors;
  int other_errors;
  int pending;
  bit stall_on;
  int cycles = 0;
  int limit = 0;

  nlc_top UUT (.*);

  nlc_checker u_check (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles with %0d results still pending", cycles, pending);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic next_cycle();
    @(negedge clk);
    out_ready = stall_on ? ($urandom % 3 != 0) : 1'b1;
  endtask

  function automatic int random_span(int span);
    return int'($urandom % (2 * span)) - span;
  endfunction

  task automatic write_word(ch_t c, coef_sel_e sel, word_t d);
    coef_we = 1'b1;
    coef_ch = c;
    coef_sel = sel;
    coef_data = d;
    next_cycle();
    coef_we = 1'b0;
  endtask

  task automatic load_coefs(int set, ch_t c);
    word_t w [8];
    for (int i = 0; i < 8; i++) begin
      w[i] = '0;
    end
    w[SEL_RECIP] = 32'h0001_0000;
    case (set)
      SET_IDENT: w[SEL_C1] = 32'h0001_0000;
      SET_SATP:  w[SEL_C0] = 32'h7fff_0000;
      SET_SATN:  w[SEL_C0] = 32'h8000_0000;
      default: begin
        // Smaller weights on higher powers
        w[SEL_NEG_MEAN] = word_t'(random_span(1024) * 65536);
        w[SEL_RECIP] = word_t'(16 + $urandom % 240);
        w[SEL_C0] = word_t'(random_span(1 << 20));
        w[SEL_C1] = word_t'(random_span(1 << 17));
        w[SEL_C2] = word_t'(random_span(1 << 12));
        w[SEL_C3] = word_t'(random_span(1 << 10));
        w[SEL_C4] = word_t'(random_span(1 << 8));
        w[SEL_C5] = word_t'(random_span(1 << 6));
      end
    endcase
    for (int i = 0; i < 8; i++) begin
      write_word(c, coef_sel_e'(i), w[i]);
    end
  endtask

  task automatic send_sample(ch_t c, adc_t s);
    logic taken;
    in_valid = 1'b1;
    in_ch = c;
    in_sample = s;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready;
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic run_row(int r);
    int span;
    ch_t c;
    test_name = row_name[r];
    stall_on = row_stall[r];
    for (int k = 0; k < row_nch[r]; k++) begin
      load_coefs(row_set[r], ch_t'(row_ch[r] + k));
    end
    // Sample shifted into Q16.16 must not wrap for the polynomial rows
    span = (row_set[r] == SET_SATP || row_set[r] == SET_SATN) ? (1 << 20) : (1 << 14);
    for (int n = 0; n < row_nsamp[r]; n++) begin
      c = ch_t'(row_ch[r] + $urandom % row_nch[r]);
      send_sample(c, adc_t'(random_span(span)));
    end
    while (pending != 0) begin
      next_cycle();
    end
    stall_on = 1'b0;
  endtask

  initial begin
    void'($urandom(28));
    clk = 1'b0;
    rst = 1'b1;
    coef_we = 1'b0;
    coef_ch = '0;
    coef_sel = SEL_NEG_MEAN;
    coef_data = '0;
    in_valid = 1'b0;
    in_ch = '0;
    in_sample = '0;
    out_ready = 1'b1;
    stall_on = 1'b0;
    test_name = "reset";
    for (int r = 0; r < NROWS; r++) begin
      limit += row_nsamp[r] * 4 + 40;
    end
    limit += 100;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    next_cycle();
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    repeat (2) next_cycle();
    $display("Errors: value %0d, channel %0d, other %0d", value_errors, chan_errors,
             other_errors);
    if (value_errors + chan_errors + other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/nlc_pkg.sv
verilog/nlc_coef_bank.sv
verilog/nlc_normalize.sv
verilog/nlc_horner_step.sv
verilog/nlc_output_stage.sv
verilog/nlc_top.sv
bench/nlc_checker.sv
bench/nlc_tb.sv

//--- verilog/nlc_cfg.svh
`ifndef NLC_CFG_SVH
`define NLC_CFG_SVH

// Channel table size
`define NLC_CHANNELS 16
`define NLC_CH_W 4

// ADC sample and result width, Q16.16 datapath
`define NLC_ADC_W 21
`define NLC_WORD_W 32
`define NLC_FRAC 16
`define NLC_ORDER 5

`endif

//--- verilog/nlc_coef_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_coef_bank
  import nlc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      coef_we,
  input  ch_t       coef_ch,
  input  coef_sel_e coef_sel,
  input  word_t     coef_data,

  input  ch_t       norm_ch,
  output word_t     neg_mean,
  output word_t     recip,
  output word_t     c5,

  input  ch_t       step_ch [`NLC_ORDER],
  output word_t     step_coef [`NLC_ORDER]
);

  localparam int NUM_SEL = 2 ** $bits(coef_sel_e);

  // Eight words per channel, second index is the select code
  word_t tbl [`NLC_CHANNELS][NUM_SEL];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < `NLC_CHANNELS; c++) begin
        for (int s = 0; s < NUM_SEL; s++) begin
          tbl[c][s] <= '0;
        end
      end
    end else if (coef_we) begin
      tbl[coef_ch][coef_sel] <= coef_data;
    end
  end

  // Normalize stage reads, c5 seeds the accumulator
  assign neg_mean = tbl[norm_ch][SEL_NEG_MEAN];
  assign recip    = tbl[norm_ch][SEL_RECIP];
  assign c5       = tbl[norm_ch][SEL_C5];

  // Step 0 adds c4, the last step adds c0
  for (genvar i = 0; i < `NLC_ORDER; i++) begin : g_step_rd
    assign step_coef[i] = tbl[step_ch[i]][int'(SEL_C0) + `NLC_ORDER - 1 - i];
  end

endmodule

`default_nettype wire

//--- verilog/nlc_horner_step.sv
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_horner_step
  import nlc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  advance,

  input  logic  prev_valid,
  input  ch_t   prev_ch,
  input  word_t prev_norm,
  input  word_t prev_acc,

  input  word_t coef,

  output logic  valid,
  output ch_t   ch,
  output word_t norm,
  output word_t acc
);

  word_t acc_next;

  // One Horner step, acc * x + c
  assign acc_next = fx_mul(prev_acc, prev_norm) + coef;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (advance) begin
      valid <= prev_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      ch   <= prev_ch;
      norm <= prev_norm;
      acc  <= acc_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/nlc_normalize.sv
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_normalize
  import nlc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  advance,

  input  logic  in_valid,
  input  ch_t   in_ch,
  input  adc_t  in_sample,

  input  word_t neg_mean,
  input  word_t recip,
  input  word_t c5,
  output ch_t   bank_ch,

  output logic  valid,
  output ch_t   ch,
  output word_t norm,
  output word_t acc
);

  word_t samp_q;
  word_t centered;

  // Bank lookup happens in the same cycle as acceptance
  assign bank_ch = in_ch;

  // Sample into Q16.16, top bits wrap
  assign samp_q   = word_t'(in_sample) <<< `NLC_FRAC;
  assign centered = samp_q + neg_mean;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (advance) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      ch   <= in_ch;
      norm <= fx_mul(centered, recip);
      acc  <= c5;
    end
  end

endmodule

`default_nettype wire

//--- verilog/nlc_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_output_stage
  import nlc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  input  logic  prev_valid,
  input  ch_t   prev_ch,
  input  word_t prev_acc,

  input  logic  out_ready,
  output logic  advance,

  output logic  out_valid,
  output ch_t   out_ch,
  output adc_t  out_result
);

  localparam adc_t RES_MAX = {1'b0, {(`NLC_ADC_W-1){1'b1}}};
  localparam adc_t RES_MIN = {1'b1, {(`NLC_ADC_W-1){1'b0}}};

  word_t shifted;
  adc_t  clamped;

  // Whole pipeline moves unless a held result is waiting
  assign advance = !out_valid || out_ready;

  // Drop fraction bits, then clamp into the ADC range
  assign shifted = prev_acc >>> `NLC_FRAC;

  always_comb begin
    if (shifted > word_t'(RES_MAX)) begin
      clamped = RES_MAX;
    end else if (shifted < word_t'(RES_MIN)) begin
      clamped = RES_MIN;
    end else begin
      clamped = shifted[`NLC_ADC_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= prev_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_ch     <= prev_ch;
      out_result <= clamped;
    end
  end

endmodule

`default_nettype wire

//--- verilog/nlc_pkg.sv
`default_nettype none

`include "nlc_cfg.svh"

package nlc_pkg;

  typedef logic signed [`NLC_WORD_W-1:0] word_t;
  typedef logic signed [`NLC_ADC_W-1:0] adc_t;
  typedef logic [`NLC_CH_W-1:0] ch_t;

  // Which stored word a coefficient write targets
  typedef enum logic [2:0] {
    SEL_NEG_MEAN, SEL_RECIP, SEL_C0, SEL_C1, SEL_C2, SEL_C3, SEL_C4, SEL_C5
  } coef_sel_e;

  // Q16.16 product, wraps to the low word after the shift
  function automatic word_t fx_mul(word_t a, word_t b);
    logic signed [2*`NLC_WORD_W-1:0] p;
    p = a * b;
    return p[`NLC_FRAC +: `NLC_WORD_W];
  endfunction

endpackage

`default_nettype wire

//--- verilog/nlc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "nlc_cfg.svh"

module nlc_top
  import nlc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      coef_we,
  input  ch_t       coef_ch,
  input  coef_sel_e coef_sel,
  input  word_t     coef_data,

  input  logic      in_valid,
  input  ch_t       in_ch,
  input  adc_t      in_sample,
  output logic      in_ready,

  output logic      out_valid,
  output ch_t       out_ch,
  output adc_t      out_result,
  input  logic      out_ready
);

  logic  advance;

  // Stage 0 is normalize, stages 1 to ORDER are the Horner steps
  logic  valid_s [`NLC_ORDER+1];
  ch_t   ch_s    [`NLC_ORDER+1];
  word_t norm_s  [`NLC_ORDER+1];
  word_t acc_s   [`NLC_ORDER+1];

  ch_t   bank_ch;
  word_t neg_mean;
  word_t recip;
  word_t c5;
  ch_t   step_ch   [`NLC_ORDER];
  word_t step_coef [`NLC_ORDER];

  assign in_ready = advance;

  nlc_coef_bank u_bank (
    .clk       (clk),
    .rst       (rst),
    .coef_we   (coef_we),
    .coef_ch   (coef_ch),
    .coef_sel  (coef_sel),
    .coef_data (coef_data),
    .norm_ch   (bank_ch),
    .neg_mean  (neg_mean),
    .recip     (recip),
    .c5        (c5),
    .step_ch   (step_ch),
    .step_coef (step_coef)
  );

  nlc_normalize u_norm (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .in_valid  (in_valid),
    .in_ch     (in_ch),
    .in_sample (in_sample),
    .neg_mean  (neg_mean),
    .recip     (recip),
    .c5        (c5),
    .bank_ch   (bank_ch),
    .valid     (valid_s[0]),
    .ch        (ch_s[0]),
    .norm      (norm_s[0]),
    .acc       (acc_s[0])
  );

  for (genvar i = 0; i < `NLC_ORDER; i++) begin : g_step
    // Coefficient follows the channel entering this step
    assign step_ch[i] = ch_s[i];

    nlc_horner_step u_step (
      .clk        (clk),
      .rst        (rst),
      .advance    (advance),
      .prev_valid (valid_s[i]),
      .prev_ch    (ch_s[i]),
      .prev_norm  (norm_s[i]),
      .prev_acc   (acc_s[i]),
      .coef       (step_coef[i]),
      .valid      (valid_s[i+1]),
      .ch         (ch_s[i+1]),
      .norm       (norm_s[i+1]),
      .acc        (acc_s[i+1])
    );
  end

  nlc_output_stage u_out (
    .clk        (clk),
    .rst        (rst),
    .prev_valid (valid_s[`NLC_ORDER]),
    .prev_ch    (ch_s[`NLC_ORDER]),
    .prev_acc   (acc_s[`NLC_ORDER]),
    .out_ready  (out_ready),
    .advance    (advance),
    .out_valid  (out_valid),
    .out_ch     (out_ch),
    .out_result (out_result)
  );

endmodule

`default_nettype wire
